//--- src/io_pkg.sv
package io_pkg;

    localparam int DATA_W = 16;

    // Byte addresses of word registers with bit 0 always zero on the bus
    localparam logic [15:0] ADDR_UART        = 16'hfffa;
    localparam logic [15:0] ADDR_IRQ_PENDING = 16'hfff4;
    localparam logic [15:0] ADDR_IRQ_MASK    = 16'hfff6;
    localparam logic [15:0] ADDR_TIMER       = 16'hffee;

    localparam int CLKS_PER_BIT = 8;   // Serial bit period in clocks

    localparam int IRQ_TIMER = 0;
    localparam int IRQ_UART  = 1;
    localparam int NUM_IRQ   = 8;   // Lines 2 and up are external

    localparam int UART_BUSY_BIT = 8;

endpackage

//--- src/uart_tx_fsm.sv
module uart_tx_fsm (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic [7:0] tx_byte,
    output logic       busy,
    output logic       done,
    output logic       tx
);

    enum logic [1:0] {IDLE, START_BIT, DATA_BITS, STOP_BIT} state;

    logic [15:0] bit_cnt;   // Clocks within the current bit
    logic [2:0]  bit_idx;
    logic [7:0]  shift;
    logic        bit_end;

    assign bit_end = (bit_cnt == 16'(io_pkg::CLKS_PER_BIT - 1));

    // Start counts as busy so a back-to-back write cannot slip in
    assign busy = start | (state != IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            tx      <= 1'b1;
            done    <= 1'b0;
            bit_cnt <= '0;
            bit_idx <= '0;
        end else begin
            done    <= 1'b0;
            bit_cnt <= bit_end ? '0 : bit_cnt + 16'd1;

            case (state)
                IDLE: begin
                    bit_cnt <= '0;
                    if (start) begin
                        state <= START_BIT;
                        tx    <= 1'b0;
                    end
                end
                START_BIT: if (bit_end) begin
                    state   <= DATA_BITS;
                    tx      <= shift[0];   // LSB first
                    bit_idx <= '0;
                end
                DATA_BITS: if (bit_end) begin
                    if (bit_idx == 3'd7) begin
                        state <= STOP_BIT;
                        tx    <= 1'b1;
                    end else begin
                        bit_idx <= bit_idx + 3'd1;
                        tx      <= shift[1];
                    end
                end
                default: if (bit_end) begin
                    state <= IDLE;
                    done  <= 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            shift <= tx_byte;
        end else if (state == DATA_BITS && bit_end) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

endmodule

//--- src/io_decoder.sv
module io_decoder (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      io_access,
    input  logic [15:1]               io_addr,
    output logic                      uart_cs,
    output logic                      timer_cs,
    output logic                      irq_cs,
    input  logic                      uart_ack,
    input  logic                      timer_ack,
    input  logic                      irq_ack,
    input  logic [io_pkg::DATA_W-1:0] uart_rdata,
    input  logic [io_pkg::DATA_W-1:0] timer_rdata,
    input  logic [io_pkg::DATA_W-1:0] irq_rdata,
    output logic [io_pkg::DATA_W-1:0] io_rdata,
    output logic                      io_ack
);

    logic default_cs;
    logic default_ack;

    always_comb begin
        uart_cs    = 1'b0;
        timer_cs   = 1'b0;
        irq_cs     = 1'b0;
        default_cs = 1'b0;

        if (io_access) begin
            case ({io_addr, 1'b0})
                io_pkg::ADDR_UART:  uart_cs  = 1'b1;
                io_pkg::ADDR_TIMER: timer_cs = 1'b1;
                io_pkg::ADDR_IRQ_PENDING,
                io_pkg::ADDR_IRQ_MASK: irq_cs = 1'b1;
                default: default_cs = 1'b1;   // Unmapped address still answered
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            default_ack <= 1'b0;
        end else begin
            default_ack <= default_cs;
        end
    end

    // Idle responders drive zero so a plain OR merges them
    assign io_ack   = uart_ack | timer_ack | irq_ack | default_ack;
    assign io_rdata = uart_rdata | timer_rdata | irq_rdata;

endmodule

//--- src/tick_timer.sv
module tick_timer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cs,
    input  logic                      wr_en,
    input  logic [io_pkg::DATA_W-1:0] wdata,
    output logic [io_pkg::DATA_W-1:0] rdata,
    output logic                      ack,
    output logic                      tick
);

    logic [io_pkg::DATA_W-1:0] reload;
    logic [io_pkg::DATA_W-1:0] count;
    logic                      rd_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            reload <= '0;   // Zero reload means stopped
            count  <= '0;
            ack    <= 1'b0;
            rd_q   <= 1'b0;
            tick   <= 1'b0;
        end else begin
            ack  <= cs;
            rd_q <= cs & ~wr_en;
            tick <= 1'b0;

            if (cs && wr_en) begin
                reload <= wdata;
                count  <= wdata;
            end else if (reload != '0) begin
                if (count == 16'd1) begin
                    count <= reload;   // Period is exactly reload cycles
                    tick  <= 1'b1;
                end else begin
                    count <= count - 16'd1;
                end
            end
        end
    end

    assign rdata = rd_q ? count : '0;

endmodule

//--- src/uart_port.sv
module uart_port (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      cs,
    input  logic                      wr_en,
    input  logic [io_pkg::DATA_W-1:0] wdata,
    output logic [io_pkg::DATA_W-1:0] rdata,
    output logic                      ack,
    output logic                      tx_done,
    output logic                      uart_tx
);

    logic       start;
    logic       busy;
    logic       rd_q;
    logic [7:0] tx_byte;

    always_ff @(posedge clk) begin
        if (rst) begin
            ack   <= 1'b0;
            rd_q  <= 1'b0;
            start <= 1'b0;
        end else begin
            ack   <= cs;
            rd_q  <= cs & ~wr_en;
            start <= cs & wr_en & ~busy;   // Writes while busy are dropped
        end
    end

    always_ff @(posedge clk) begin
        if (cs && wr_en && !busy) begin
            tx_byte <= wdata[7:0];
        end
    end

    // Status word carries only the busy flag
    always_comb begin
        rdata = '0;
        rdata[io_pkg::UART_BUSY_BIT] = rd_q & busy;
    end

    uart_tx_fsm u_uart_tx_fsm (
        .clk     (clk),
        .rst     (rst),
        .start   (start),
        .tx_byte (tx_byte),
        .busy    (busy),
        .done    (tx_done),
        .tx      (uart_tx)
    );

endmodule

//--- src/irq_controller.sv
module irq_controller (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cs,
    input  logic                       wr_en,
    input  logic                       addr_hi,
    input  logic [io_pkg::DATA_W-1:0]  wdata,
    input  logic [io_pkg::NUM_IRQ-1:0] intr_in,
    output logic [io_pkg::DATA_W-1:0]  rdata,
    output logic                       ack,
    output logic                       intr
);

    logic [io_pkg::NUM_IRQ-1:0] pending;
    logic [io_pkg::NUM_IRQ-1:0] mask;
    logic [io_pkg::NUM_IRQ-1:0] clr;
    logic                       rd_q;
    logic                       rd_hi;

    // Write-one-to-clear on the pending address
    assign clr = (cs && wr_en && !addr_hi) ? wdata[io_pkg::NUM_IRQ-1:0] : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
            mask    <= '0;
            ack     <= 1'b0;
            rd_q    <= 1'b0;
            rd_hi   <= 1'b0;
        end else begin
            ack     <= cs;
            rd_q    <= cs & ~wr_en;
            rd_hi   <= addr_hi;
            pending <= (pending & ~clr) | intr_in;   // New request beats clear

            if (cs && wr_en && addr_hi) begin
                mask <= wdata[io_pkg::NUM_IRQ-1:0];
            end
        end
    end

    always_comb begin
        rdata = '0;
        if (rd_q) begin
            rdata[io_pkg::NUM_IRQ-1:0] = rd_hi ? mask : pending;
        end
    end

    assign intr = |(pending & mask);

endmodule

//--- src/io_top.sv
module io_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      io_access,
    input  logic                      io_wr_en,
    input  logic [15:1]               io_addr,
    input  logic [io_pkg::DATA_W-1:0] io_wdata,
    output logic [io_pkg::DATA_W-1:0] io_rdata,
    output logic                      io_ack,
    input  logic [5:0]                ext_irq,
    output logic                      intr,
    output logic                      uart_tx
);

    logic                       uart_cs;
    logic                       timer_cs;
    logic                       irq_cs;
    logic                       uart_ack;
    logic                       timer_ack;
    logic                       irq_ack;
    logic [io_pkg::DATA_W-1:0]  uart_rdata;
    logic [io_pkg::DATA_W-1:0]  timer_rdata;
    logic [io_pkg::DATA_W-1:0]  irq_rdata;
    logic                       timer_tick;
    logic                       uart_done;
    logic [io_pkg::NUM_IRQ-1:0] irq_req;

    always_comb begin
        irq_req = '0;
        irq_req[io_pkg::NUM_IRQ-1:2]  = ext_irq;
        irq_req[io_pkg::IRQ_TIMER]    = timer_tick;
        irq_req[io_pkg::IRQ_UART]     = uart_done;
    end

    io_decoder u_io_decoder (
        .clk         (clk),
        .rst         (rst),
        .io_access   (io_access),
        .io_addr     (io_addr),
        .uart_cs     (uart_cs),
        .timer_cs    (timer_cs),
        .irq_cs      (irq_cs),
        .uart_ack    (uart_ack),
        .timer_ack   (timer_ack),
        .irq_ack     (irq_ack),
        .uart_rdata  (uart_rdata),
        .timer_rdata (timer_rdata),
        .irq_rdata   (irq_rdata),
        .io_rdata    (io_rdata),
        .io_ack      (io_ack)
    );

    uart_port u_uart_port (
        .clk     (clk),
        .rst     (rst),
        .cs      (uart_cs),
        .wr_en   (io_wr_en),
        .wdata   (io_wdata),
        .rdata   (uart_rdata),
        .ack     (uart_ack),
        .tx_done (uart_done),
        .uart_tx (uart_tx)
    );

    tick_timer u_tick_timer (
        .clk   (clk),
        .rst   (rst),
        .cs    (timer_cs),
        .wr_en (io_wr_en),
        .wdata (io_wdata),
        .rdata (timer_rdata),
        .ack   (timer_ack),
        .tick  (timer_tick)
    );

    irq_controller u_irq_controller (
        .clk     (clk),
        .rst     (rst),
        .cs      (irq_cs),
        .wr_en   (io_wr_en),
        .addr_hi (io_addr[1]),   // Pending at the low word and mask at the high
        .wdata   (io_wdata),
        .intr_in (irq_req),
        .rdata   (irq_rdata),
        .ack     (irq_ack),
        .intr    (intr)
    );

endmodule

//--- bench/io_top_tb.sv
module io_top_tb;

    localparam int BIT_CYCLES   = io_pkg::CLKS_PER_BIT;
    localparam int FRAME_CYCLES = 10 * BIT_CYCLES;   // Start bit, eight data bits and stop bit
    localparam int TIMER_N      = 5;
    // Three frames and one idle gap plus the bus traffic around them
    localparam int RUN_CYCLES   = 16 + 6 * FRAME_CYCLES + 400;

    localparam logic [15:0] BUSY_WORD  = 16'h1 << io_pkg::UART_BUSY_BIT;
    localparam logic [15:0] TIMER_WORD = 16'h1 << io_pkg::IRQ_TIMER;
    localparam logic [15:0] UART_WORD  = 16'h1 << io_pkg::IRQ_UART;

    logic        clk;
    logic        rst;
    logic        io_access;
    logic        io_wr_en;
    logic [15:1] io_addr;
    logic [15:0] io_wdata;
    logic [15:0] io_rdata;
    logic        io_ack;
    logic [5:0]  ext_irq;
    logic        intr;
    logic        uart_tx;

    int         seed = 32'h6eb1;
    logic [7:0] rx_q[$];   // Bytes seen by the serial monitor

    io_top u_io_top (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    // One word access with the ack due in the very next cycle
    task automatic bus_cycle(input logic wr, input logic [15:0] addr,
                             input logic [15:0] wdata, output logic [15:0] rdata);
        @(posedge clk);
        #2;
        io_access = 1'b1;
        io_wr_en  = wr;
        io_addr   = addr[15:1];
        io_wdata  = wdata;
        @(posedge clk);
        #2;
        io_access = 1'b0;
        io_wr_en  = 1'b0;
        assert (io_ack === 1'b1) else begin
            $display("No acknowledge in the cycle after the access to %h", addr);
            $display("=== FAIL ===");
            $fatal(1);
        end
        rdata = io_rdata;
    endtask

    task automatic io_write(input logic [15:0] addr, input logic [15:0] wdata);
        logic [15:0] ignored;
        bus_cycle(1'b1, addr, wdata, ignored);
    endtask

    task automatic io_read(input logic [15:0] addr, output logic [15:0] rdata);
        bus_cycle(1'b0, addr, 16'h0000, rdata);
    endtask

    // Serial line monitor sampling each bit near its middle
    initial begin : serial_monitor
        logic [7:0] rx_byte;
        @(negedge rst);
        forever begin
            @(posedge clk);
            #1;
            if (uart_tx === 1'b0) begin
                repeat (BIT_CYCLES / 2) @(posedge clk);
                #1;
                check("uart_tx start bit", 16'(uart_tx), 16'h0000);
                for (int i = 0; i < 8; i++) begin
                    repeat (BIT_CYCLES) @(posedge clk);
                    #1;
                    rx_byte[i] = uart_tx;   // LSB first
                end
                repeat (BIT_CYCLES) @(posedge clk);
                #1;
                check("uart_tx stop bit", 16'(uart_tx), 16'h0001);
                rx_q.push_back(rx_byte);
            end
        end
    end

    task automatic wait_frame(output logic [7:0] rx_byte);
        int cycles;
        cycles = 0;
        while (rx_q.size() == 0 && cycles < 2 * FRAME_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        assert (rx_q.size() != 0) else begin
            $display("No UART frame was received within %0d cycles", 2 * FRAME_CYCLES);
            $display("=== FAIL ===");
            $fatal(1);
        end
        rx_byte = rx_q.pop_front();
    endtask

    task automatic reset_defaults();
        logic [15:0] data;
        check("uart_tx", 16'(uart_tx), 16'h0001);
        check("intr", 16'(intr), 16'h0000);
        check("io_ack", 16'(io_ack), 16'h0000);
        io_read(16'h1234, data);   // Unmapped
        check("io_rdata unmapped", data, 16'h0000);
        io_read(io_pkg::ADDR_IRQ_PENDING, data);
        check("irq pending", data, 16'h0000);
        io_read(io_pkg::ADDR_IRQ_MASK, data);
        check("irq mask", data, 16'h0000);
        io_read(io_pkg::ADDR_TIMER, data);
        check("timer count", data, 16'h0000);
    endtask

    task automatic uart_frame_and_status();
        logic [31:0] rnd;
        logic [15:0] data;
        logic [7:0]  rx_byte;
        rnd = $random(seed);
        io_write(io_pkg::ADDR_UART, {8'h00, rnd[7:0]});
        check("uart_tx before start", 16'(uart_tx), 16'h0001);
        @(posedge clk);
        #2;
        check("uart_tx start", 16'(uart_tx), 16'h0000);
        io_read(io_pkg::ADDR_UART, data);
        check("uart status busy", data, BUSY_WORD);
        wait_frame(rx_byte);
        check("uart_tx frame byte", {8'h00, rx_byte}, {8'h00, rnd[7:0]});
        repeat (BIT_CYCLES) @(posedge clk);   // Rest of the stop bit
        io_read(io_pkg::ADDR_UART, data);
        check("uart status idle", data, 16'h0000);
    endtask

    task automatic uart_drop_while_busy();
        logic [7:0] rx_byte;
        io_write(io_pkg::ADDR_UART, 16'h00a5);
        io_write(io_pkg::ADDR_UART, 16'h005a);
        wait_frame(rx_byte);
        check("uart_tx frame byte", {8'h00, rx_byte}, 16'h00a5);
        repeat (FRAME_CYCLES + 2 * BIT_CYCLES) @(posedge clk);
        check("uart frames after drop", 16'(rx_q.size()), 16'h0000);
    endtask

    task automatic timer_period();
        logic [15:0] data;
        int          elapsed;
        io_write(io_pkg::ADDR_IRQ_PENDING, 16'h00ff);
        io_write(io_pkg::ADDR_TIMER, 16'(TIMER_N));
        elapsed = 0;
        // Reads land two cycles apart while the count runs N down to 1
        for (int i = 0; i < 3 * TIMER_N; i++) begin
            io_read(io_pkg::ADDR_TIMER, data);
            elapsed += 2;
            check("timer count", data, 16'(TIMER_N - elapsed % TIMER_N));
        end
        io_read(io_pkg::ADDR_IRQ_PENDING, data);
        check("irq pending", data, TIMER_WORD);
        io_write(io_pkg::ADDR_TIMER, 16'h0000);
        io_write(io_pkg::ADDR_IRQ_PENDING, 16'h00ff);
        repeat (3 * TIMER_N) @(posedge clk);
        io_read(io_pkg::ADDR_IRQ_PENDING, data);
        check("irq pending stopped", data, 16'h0000);
    endtask

    task automatic irq_pend_and_mask();
        logic [31:0] rnd;
        logic [5:0]  ext;
        logic [15:0] pend;
        logic [15:0] data;
        rnd  = $random(seed);
        ext  = rnd[5:0] | 6'b000100;   // Line 4 always among them
        pend = {8'h00, ext, 2'b00};
        io_write(io_pkg::ADDR_IRQ_PENDING, 16'h00ff);
        @(posedge clk);
        #2;
        ext_irq = ext;
        @(posedge clk);
        #2;
        ext_irq = 6'b000000;
        io_read(io_pkg::ADDR_IRQ_PENDING, data);
        check("irq pending", data, pend);
        check("intr", 16'(intr), 16'h0000);
        io_write(io_pkg::ADDR_IRQ_MASK, 16'h0010);
        check("intr", 16'(intr), 16'h0001);
        io_read(io_pkg::ADDR_IRQ_MASK, data);
        check("irq mask", data, 16'h0010);
        io_write(io_pkg::ADDR_IRQ_PENDING, 16'h0010);
        io_read(io_pkg::ADDR_IRQ_PENDING, data);
        check("irq pending", data, pend & ~16'h0010);
        check("intr", 16'(intr), 16'h0000);
        io_write(io_pkg::ADDR_IRQ_PENDING, 16'h00ff);
        io_write(io_pkg::ADDR_IRQ_MASK, 16'h0000);
    endtask

    task automatic uart_done_irq();
        logic [15:0] data;
        logic [7:0]  rx_byte;
        io_write(io_pkg::ADDR_IRQ_PENDING, 16'h00ff);
        io_write(io_pkg::ADDR_UART, 16'h003c);
        wait_frame(rx_byte);
        repeat (BIT_CYCLES) @(posedge clk);
        io_read(io_pkg::ADDR_IRQ_PENDING, data);
        check("irq pending", data, UART_WORD);
        check("intr", 16'(intr), 16'h0000);
        io_write(io_pkg::ADDR_IRQ_MASK, UART_WORD);
        check("intr", 16'(intr), 16'h0001);
        io_write(io_pkg::ADDR_IRQ_PENDING, UART_WORD);
        check("intr", 16'(intr), 16'h0000);
        io_write(io_pkg::ADDR_IRQ_MASK, 16'h0000);
    endtask

    initial begin
        rst       = 1'b1;
        io_access = 1'b0;
        io_wr_en  = 1'b0;
        io_addr   = '0;
        io_wdata  = '0;
        ext_irq   = '0;
        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        reset_defaults();
        uart_frame_and_status();
        uart_drop_while_busy();
        timer_period();
        irq_pend_and_mask();
        uart_done_irq();
        $display("=== PASS ===");
        $finish;
    end

    initial begin : watchdog
        repeat (RUN_CYCLES) @(posedge clk);
        $display("Run did not finish within %0d cycles", RUN_CYCLES);
        $display("=== FAIL ===");
        $fatal(1);
    end

endmodule

//--- all.f
src/io_pkg.sv
src/uart_tx_fsm.sv
src/io_decoder.sv
src/tick_timer.sv
src/uart_port.sv
src/irq_controller.sv
src/io_top.sv
bench/io_top_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module io_top_tb -f all.f -o io_top_tb
./obj_dir/io_top_tb
